// ==== include/i3c_phy_settings.svh ====
// Port count, AXI4-Lite address width and register map offsets of the I3C PHY
`ifndef I3C_PHY_SETTINGS_SVH
`define I3C_PHY_SETTINGS_SVH

// Number of lanes, one register bit per lane, at most 16
`define I3C_NUM_PORTS 4

// Byte address width of the register front end
`define I3C_AXIL_ADDR_W 8

// Register map, byte offsets
`define I3C_REG_SCL_OUT 'h00
`define I3C_REG_SDA_OUT 'h04
`define I3C_REG_ARB_EN 'h08
`define I3C_REG_BUS 'h0C
`define I3C_REG_ERR 'h10
`define I3C_REG_IRQ_EN 'h14

`endif

// ==== hdl/i3c_phy_pkg.sv ====
// Lane control, lane state, lane error and AXI4-Lite request and response types
`default_nettype none

`include "i3c_phy_settings.svh"

package i3c_phy_pkg;

  // Levels requested by software for one lane
  typedef struct packed {
    logic scl_val;
    logic sda_val;
    logic arb_en;
  } i3c_lane_ctrl_t;

  // Synchronized line levels, low while the lane drives
  typedef struct packed {
    logic scl;
    logic sda;
  } i3c_lane_state_t;

  // Interference flags of one lane
  typedef struct packed {
    logic scl_err;
    logic sda_err;
  } i3c_phy_err_t;

  typedef struct packed {
    logic [`I3C_AXIL_ADDR_W-1:0] awaddr;
    logic                        awvalid;
    logic [31:0]                 wdata;
    logic [3:0]                  wstrb;
    logic                        wvalid;
    logic                        bready;
    logic [`I3C_AXIL_ADDR_W-1:0] araddr;
    logic                        arvalid;
    logic                        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/dff_2sync.sv ====
// Two-stage synchronizer for one asynchronous bit, clears to zero on reset
`timescale 1ns/1ps
`default_nettype none

module dff_2sync (
  input  logic clk,
  input  logic rst_n,
  input  logic d_i,
  output logic q_o
);

  logic meta_q;
  logic sync_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

`default_nettype wire

// ==== hdl/i3c_phy.sv ====
// Open-drain I3C lane with enable generation, line synchronizers and interference check
`timescale 1ns/1ps
`default_nettype none

module i3c_phy (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          scl_i,
  output logic                          scl_en_o,
  input  logic                          sda_i,
  output logic                          sda_en_o,
  input  i3c_phy_pkg::i3c_lane_ctrl_t   lane_ctrl_i,
  output i3c_phy_pkg::i3c_lane_state_t  lane_state_o,
  output i3c_phy_pkg::i3c_phy_err_t     phy_err_o
);

  // Requested open-drain enables, high pulls the line low
  logic scl_en_req;
  logic sda_en_req;

  logic scl_sync;
  logic sda_sync;
  logic scl_en_sync;
  logic sda_en_sync;
  logic arb_en_sync;

  // Enable history, lined up with the latency of the line synchronizers
  logic [1:0] scl_en_dly_q;
  logic [1:0] sda_en_dly_q;

  logic scl_err_q;
  logic sda_err_q;

  assign scl_en_req = ~lane_ctrl_i.scl_val;
  assign sda_en_req = ~lane_ctrl_i.sda_val;

  dff_2sync u_scl_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (scl_i),
    .q_o   (scl_sync)
  );

  dff_2sync u_sda_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (sda_i),
    .q_o   (sda_sync)
  );

  dff_2sync u_scl_en_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (scl_en_req),
    .q_o   (scl_en_sync)
  );

  dff_2sync u_sda_en_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (sda_en_req),
    .q_o   (sda_en_sync)
  );

  dff_2sync u_arb_en_sync (
    .clk   (clk),
    .rst_n (rst_n),
    .d_i   (lane_ctrl_i.arb_en),
    .q_o   (arb_en_sync)
  );

  // Pad value is tied low outside, only the enables leave the lane
  assign scl_en_o = scl_en_sync;
  assign sda_en_o = sda_en_sync;

  assign lane_state_o.scl = scl_en_sync ? 1'b0 : scl_sync;
  assign lane_state_o.sda = sda_en_sync ? 1'b0 : sda_sync;

  // A synchronized sample shows the pad as it was two cycles back, so the
  // compare uses the enable of that same cycle to avoid a false flag on release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scl_en_dly_q <= 2'b00;
      sda_en_dly_q <= 2'b00;
      scl_err_q    <= 1'b0;
      sda_err_q    <= 1'b0;
    end else begin
      scl_en_dly_q <= {scl_en_dly_q[0], scl_en_sync};
      sda_en_dly_q <= {sda_en_dly_q[0], sda_en_sync};
      // Released but read low means another device holds the line
      scl_err_q    <= arb_en_sync & ~scl_en_dly_q[1] & ~scl_sync;
      sda_err_q    <= arb_en_sync & ~sda_en_dly_q[1] & ~sda_sync;
    end
  end

  assign phy_err_o.scl_err = scl_err_q;
  assign phy_err_o.sda_err = sda_err_q;

endmodule

`default_nettype wire

// ==== hdl/i3c_phy_regs.sv ====
// AXI4-Lite slave with line control, arbitration, bus status, error and interrupt registers
`timescale 1ns/1ps
`default_nettype none

`include "i3c_phy_settings.svh"

module i3c_phy_regs #(
  parameter int NUM_PORTS = `I3C_NUM_PORTS
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  i3c_phy_pkg::axil_req_t        axil_req_i,
  output i3c_phy_pkg::axil_rsp_t        axil_rsp_o,
  output i3c_phy_pkg::i3c_lane_ctrl_t   lane_ctrl_o [NUM_PORTS],
  input  i3c_phy_pkg::i3c_lane_state_t  lane_state_i [NUM_PORTS],
  input  logic [31:0]                   err_status_i,
  output logic [31:0]                   err_clear_o,
  output logic [31:0]                   irq_en_o
);

  localparam int AW = `I3C_AXIL_ADDR_W;

  localparam logic [AW-1:0] ADDR_SCL_OUT = AW'(`I3C_REG_SCL_OUT);
  localparam logic [AW-1:0] ADDR_SDA_OUT = AW'(`I3C_REG_SDA_OUT);
  localparam logic [AW-1:0] ADDR_ARB_EN  = AW'(`I3C_REG_ARB_EN);
  localparam logic [AW-1:0] ADDR_BUS     = AW'(`I3C_REG_BUS);
  localparam logic [AW-1:0] ADDR_ERR     = AW'(`I3C_REG_ERR);
  localparam logic [AW-1:0] ADDR_IRQ_EN  = AW'(`I3C_REG_IRQ_EN);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Handshake state
  logic wr_ready_q;
  logic bvalid_q;
  logic arready_q;
  logic rvalid_q;

  logic [1:0]  bresp_q;
  logic [1:0]  rresp_q;
  logic [31:0] rdata_q;

  logic [NUM_PORTS-1:0] scl_out_q;
  logic [NUM_PORTS-1:0] sda_out_q;
  logic [NUM_PORTS-1:0] arb_en_q;
  logic [31:0]          irq_en_q;

  logic                 wr_fire;
  logic                 rd_fire;
  logic [AW-1:0]        wr_addr;
  logic [AW-1:0]        rd_addr;
  logic [31:0]          wmask;
  logic [NUM_PORTS-1:0] wmask_n;
  logic [NUM_PORTS-1:0] wdata_n;
  logic [31:0]          bus_word;
  logic [31:0]          rd_word;

  function automatic logic addr_mapped(input logic [AW-1:0] addr);
    logic hit;
    case (addr)
      ADDR_SCL_OUT, ADDR_SDA_OUT, ADDR_ARB_EN,
      ADDR_BUS, ADDR_ERR, ADDR_IRQ_EN: hit = 1'b1;
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  // Word aligned addresses
  assign wr_addr = {axil_req_i.awaddr[AW-1:2], 2'b00};
  assign rd_addr = {axil_req_i.araddr[AW-1:2], 2'b00};

  assign wr_fire = wr_ready_q & axil_req_i.awvalid & axil_req_i.wvalid;
  assign rd_fire = arready_q & axil_req_i.arvalid;

  assign wmask = {{8{axil_req_i.wstrb[3]}}, {8{axil_req_i.wstrb[2]}},
                  {8{axil_req_i.wstrb[1]}}, {8{axil_req_i.wstrb[0]}}};
  assign wmask_n = wmask[NUM_PORTS-1:0];
  assign wdata_n = axil_req_i.wdata[NUM_PORTS-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      arready_q  <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      // Address and data accepted together, one cycle pulse
      wr_ready_q <= axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q & ~wr_ready_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end

      arready_q <= axil_req_i.arvalid & ~rvalid_q & ~arready_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp_q <= addr_mapped(wr_addr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rresp_q <= addr_mapped(rd_addr) ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_word;
    end
  end

  // Lines released and checks off out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scl_out_q <= '1;
      sda_out_q <= '1;
      arb_en_q  <= '0;
      irq_en_q  <= '0;
    end else if (wr_fire) begin
      case (wr_addr)
        ADDR_SCL_OUT: scl_out_q <= (scl_out_q & ~wmask_n) | (wdata_n & wmask_n);
        ADDR_SDA_OUT: sda_out_q <= (sda_out_q & ~wmask_n) | (wdata_n & wmask_n);
        ADDR_ARB_EN:  arb_en_q  <= (arb_en_q & ~wmask_n) | (wdata_n & wmask_n);
        ADDR_IRQ_EN:  irq_en_q  <= (irq_en_q & ~wmask) | (axil_req_i.wdata & wmask);
        default: ;
      endcase
    end
  end

  // Clear mask lives only in the accepting cycle
  assign err_clear_o = (wr_fire && wr_addr == ADDR_ERR) ? (axil_req_i.wdata & wmask) : '0;
  assign irq_en_o    = irq_en_q;

  always_comb begin
    bus_word = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      bus_word[i]      = lane_state_i[i].scl;
      bus_word[16 + i] = lane_state_i[i].sda;
    end
  end

  always_comb begin
    case (rd_addr)
      ADDR_SCL_OUT: rd_word = 32'(scl_out_q);
      ADDR_SDA_OUT: rd_word = 32'(sda_out_q);
      ADDR_ARB_EN:  rd_word = 32'(arb_en_q);
      ADDR_BUS:     rd_word = bus_word;
      ADDR_ERR:     rd_word = err_status_i;
      ADDR_IRQ_EN:  rd_word = irq_en_q;
      default:      rd_word = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      lane_ctrl_o[i].scl_val = scl_out_q[i];
      lane_ctrl_o[i].sda_val = sda_out_q[i];
      lane_ctrl_o[i].arb_en  = arb_en_q[i];
    end
  end

  assign axil_rsp_o.awready = wr_ready_q;
  assign axil_rsp_o.wready  = wr_ready_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.arready = arready_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;
  assign axil_rsp_o.rvalid  = rvalid_q;

endmodule

`default_nettype wire

// ==== hdl/i3c_err_collect.sv ====
// Sticky interference status per lane and line with write-one-to-clear and level interrupt
`timescale 1ns/1ps
`default_nettype none

`include "i3c_phy_settings.svh"

module i3c_err_collect #(
  parameter int NUM_PORTS = `I3C_NUM_PORTS
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  i3c_phy_pkg::i3c_phy_err_t  phy_err_i [NUM_PORTS],
  input  logic [31:0]                err_clear_i,
  input  logic [31:0]                irq_en_i,
  output logic [31:0]                err_status_o,
  output logic                       irq_o
);

  // SCL flags in the low half, SDA flags in the high half
  logic [31:0] err_set;
  logic [31:0] sticky_q;

  always_comb begin
    err_set = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      err_set[i]      = phy_err_i[i].scl_err;
      err_set[16 + i] = phy_err_i[i].sda_err;
    end
  end

  // New error in the clear cycle survives the clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= (sticky_q & ~err_clear_i) | err_set;
    end
  end

  assign err_status_o = sticky_q;

  // Level interrupt, follows the sticky bits directly
  assign irq_o = |(sticky_q & irq_en_i);

endmodule

`default_nettype wire

// ==== hdl/i3c_phy_array.sv ====
// Multi-port I3C PHY top with register block, lane array and error collector
`timescale 1ns/1ps
`default_nettype none

`include "i3c_phy_settings.svh"

module i3c_phy_array #(
  parameter int NUM_PORTS = `I3C_NUM_PORTS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  i3c_phy_pkg::axil_req_t  axil_req_i,
  output i3c_phy_pkg::axil_rsp_t  axil_rsp_o,
  input  logic [NUM_PORTS-1:0]    scl_i,
  output logic [NUM_PORTS-1:0]    scl_en_o,
  input  logic [NUM_PORTS-1:0]    sda_i,
  output logic [NUM_PORTS-1:0]    sda_en_o,
  output logic                    irq_o
);

  import i3c_phy_pkg::*;

  i3c_lane_ctrl_t  lane_ctrl  [NUM_PORTS];
  i3c_lane_state_t lane_state [NUM_PORTS];
  i3c_phy_err_t    phy_err    [NUM_PORTS];

  logic [31:0] err_status;
  logic [31:0] err_clear;
  logic [31:0] irq_en;

  i3c_phy_regs #(
    .NUM_PORTS (NUM_PORTS)
  ) u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .lane_ctrl_o  (lane_ctrl),
    .lane_state_i (lane_state),
    .err_status_i (err_status),
    .err_clear_o  (err_clear),
    .irq_en_o     (irq_en)
  );

  // One open-drain lane per port
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
    i3c_phy u_phy (
      .clk          (clk),
      .rst_n        (rst_n),
      .scl_i        (scl_i[i]),
      .scl_en_o     (scl_en_o[i]),
      .sda_i        (sda_i[i]),
      .sda_en_o     (sda_en_o[i]),
      .lane_ctrl_i  (lane_ctrl[i]),
      .lane_state_o (lane_state[i]),
      .phy_err_o    (phy_err[i])
    );
  end

  i3c_err_collect #(
    .NUM_PORTS (NUM_PORTS)
  ) u_err_collect (
    .clk          (clk),
    .rst_n        (rst_n),
    .phy_err_i    (phy_err),
    .err_clear_i  (err_clear),
    .irq_en_i     (irq_en),
    .err_status_o (err_status),
    .irq_o        (irq_o)
  );

endmodule

`default_nettype wire

// ==== bench/i3c_phy_array_tb.sv ====
// Directed tests for the I3C PHY array with pad pull-up model, AXI4-Lite tasks and LFSR data
`timescale 1ns/1ps
`default_nettype none

`include "i3c_phy_settings.svh"

module i3c_phy_array_tb;

  import i3c_phy_pkg::*;

  localparam int NUM_PORTS   = `I3C_NUM_PORTS;
  localparam int AW          = `I3C_AXIL_ADDR_W;
  localparam int CYCLE_LIMIT = 2000;

  localparam logic [AW-1:0] A_SCL_OUT  = AW'(`I3C_REG_SCL_OUT);
  localparam logic [AW-1:0] A_SDA_OUT  = AW'(`I3C_REG_SDA_OUT);
  localparam logic [AW-1:0] A_ARB_EN   = AW'(`I3C_REG_ARB_EN);
  localparam logic [AW-1:0] A_BUS      = AW'(`I3C_REG_BUS);
  localparam logic [AW-1:0] A_ERR      = AW'(`I3C_REG_ERR);
  localparam logic [AW-1:0] A_IRQ_EN   = AW'(`I3C_REG_IRQ_EN);
  localparam logic [AW-1:0] A_UNMAPPED = AW'('h18);

  localparam logic [1:0]  OKAY      = 2'b00;
  localparam logic [1:0]  SLVERR    = 2'b10;
  localparam logic [31:0] PORTS_ALL = 32'({NUM_PORTS{1'b1}});

  logic                 clk;
  logic                 rst_n;
  axil_req_t            axil_req;
  axil_rsp_t            axil_rsp;
  logic [NUM_PORTS-1:0] scl_i;
  logic [NUM_PORTS-1:0] sda_i;
  logic [NUM_PORTS-1:0] scl_en;
  logic [NUM_PORTS-1:0] sda_en;
  logic [NUM_PORTS-1:0] scl_pull_low;
  logic [NUM_PORTS-1:0] sda_pull_low;
  logic                 irq;
  logic [31:0]          lfsr_q;
  int                   cycle_count = 0;

  i3c_phy_array DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .scl_i      (scl_i),
    .scl_en_o   (scl_en),
    .sda_i      (sda_i),
    .sda_en_o   (sda_en),
    .irq_o      (irq)
  );

  // Pull-ups hold each pad high unless the DUT drives or another device pulls
  assign scl_i = ~(scl_en | scl_pull_low);
  assign sda_i = ~(sda_en | sda_pull_low);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic axil_write(input logic [AW-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    // Ready is a one-cycle pulse sampled between edges
    do @(negedge clk); while (!axil_rsp.awready);
    check_bit("wready", axil_rsp.wready, 1'b1);
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [AW-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do @(negedge clk); while (!axil_rsp.arready);
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    do @(negedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, 4'hF, resp);
    check_resp("bresp", resp, OKAY);
  endtask

  task automatic expect_reg(input string name, input logic [AW-1:0] addr,
                            input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_resp("rresp", resp, OKAY);
    check_word(name, data, exp);
  endtask

  task automatic reset_defaults();
    check_word("scl_en_o", 32'(scl_en), '0);
    check_word("sda_en_o", 32'(sda_en), '0);
    check_bit("irq_o", irq, 1'b0);
    check_bit("awready", axil_rsp.awready, 1'b0);
    check_bit("wready", axil_rsp.wready, 1'b0);
    check_bit("arready", axil_rsp.arready, 1'b0);
    check_bit("bvalid", axil_rsp.bvalid, 1'b0);
    check_bit("rvalid", axil_rsp.rvalid, 1'b0);
    expect_reg("SCL_OUT", A_SCL_OUT, PORTS_ALL);
    expect_reg("SDA_OUT", A_SDA_OUT, PORTS_ALL);
    expect_reg("ARB_EN", A_ARB_EN, '0);
    expect_reg("ERR", A_ERR, '0);
    expect_reg("IRQ_EN", A_IRQ_EN, '0);
    // All lines released so the pull-ups win
    expect_reg("BUS", A_BUS, {PORTS_ALL[15:0], PORTS_ALL[15:0]});
  endtask

  task automatic line_control();
    logic [31:0]          r;
    logic [NUM_PORTS-1:0] scl_val;
    logic [NUM_PORTS-1:0] sda_val;
    logic [NUM_PORTS-1:0] en_exp;
    logic [31:0]          bus_exp;
    for (int n = 0; n < 3; n++) begin
      take_random(NUM_PORTS, r);
      scl_val = r[NUM_PORTS-1:0];
      take_random(NUM_PORTS, r);
      sda_val = r[NUM_PORTS-1:0];
      take_random(NUM_PORTS, r);
      scl_pull_low = r[NUM_PORTS-1:0];
      take_random(NUM_PORTS, r);
      sda_pull_low = r[NUM_PORTS-1:0];
      write_reg(A_SCL_OUT, 32'(scl_val));
      write_reg(A_SDA_OUT, 32'(sda_val));
      wait_cycles(4);
      en_exp = ~scl_val;
      check_word("scl_en_o", 32'(scl_en), 32'(en_exp));
      en_exp = ~sda_val;
      check_word("sda_en_o", 32'(sda_en), 32'(en_exp));
      bus_exp = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        bus_exp[i]      = scl_val[i] & ~scl_pull_low[i];
        bus_exp[16 + i] = sda_val[i] & ~sda_pull_low[i];
      end
      expect_reg("BUS", A_BUS, bus_exp);
      // Arbitration is off so foreign pulls leave no trace
      expect_reg("ERR", A_ERR, '0);
    end
    scl_pull_low = '0;
    sda_pull_low = '0;
    write_reg(A_SCL_OUT, PORTS_ALL);
    write_reg(A_SDA_OUT, PORTS_ALL);
    wait_cycles(4);
  endtask

  task automatic interference_flagged(input int port);
    logic [31:0] sda_bit;
    sda_bit = 32'd1 << (16 + port);
    write_reg(A_ARB_EN, 32'd1 << port);
    write_reg(A_IRQ_EN, sda_bit);
    wait_cycles(3);
    sda_pull_low[port] = 1'b1;
    for (int i = 0; i < 8 && !irq; i++) begin
      wait_cycles(1);
    end
    if (!irq) begin
      $display("Interrupt did not rise within 8 cycles of the SDA interference");
      abort_run();
    end
    expect_reg("ERR", A_ERR, sda_bit);
    sda_pull_low[port] = 1'b0;
    wait_cycles(5);
    // Status stays set after the foreign pull is gone
    check_bit("irq_o", irq, 1'b1);
    write_reg(A_ERR, sda_bit);
    check_bit("irq_o", irq, 1'b0);
    expect_reg("ERR", A_ERR, '0);
  endtask

  task automatic interference_ignored(input int port);
    write_reg(A_ARB_EN, '0);
    wait_cycles(3);
    sda_pull_low[port] = 1'b1;
    wait_cycles(10);
    expect_reg("ERR", A_ERR, '0);
    check_bit("irq_o", irq, 1'b0);
    sda_pull_low[port] = 1'b0;
    wait_cycles(4);
    // Checks on while the lanes drive and then release their own lines
    write_reg(A_ARB_EN, PORTS_ALL);
    write_reg(A_SCL_OUT, '0);
    write_reg(A_SDA_OUT, '0);
    wait_cycles(10);
    write_reg(A_SCL_OUT, PORTS_ALL);
    write_reg(A_SDA_OUT, PORTS_ALL);
    wait_cycles(10);
    expect_reg("ERR", A_ERR, '0);
    write_reg(A_ARB_EN, '0);
  endtask

  task automatic strobes_and_decode();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [31:0] data;
    logic [1:0]  resp;
    take_random(32, a);
    take_random(32, b);
    write_reg(A_IRQ_EN, a);
    axil_write(A_IRQ_EN, b, 4'b0101, resp);
    check_resp("bresp", resp, OKAY);
    exp = {a[31:24], b[23:16], a[15:8], b[7:0]};
    expect_reg("IRQ_EN", A_IRQ_EN, exp);
    axil_write(A_UNMAPPED, 32'hFFFF_FFFF, 4'hF, resp);
    check_resp("bresp", resp, SLVERR);
    axil_read(A_UNMAPPED, data, resp);
    check_resp("rresp", resp, SLVERR);
    check_word("rdata", data, '0);
    expect_reg("IRQ_EN", A_IRQ_EN, exp);
    expect_reg("SCL_OUT", A_SCL_OUT, PORTS_ALL);
    expect_reg("SDA_OUT", A_SDA_OUT, PORTS_ALL);
    expect_reg("ARB_EN", A_ARB_EN, '0);
    expect_reg("ERR", A_ERR, '0);
    write_reg(A_IRQ_EN, '0);
  endtask

  initial begin : main
    logic [31:0] r;
    int          port;
    clk          = 1'b0;
    rst_n        = 1'b0;
    axil_req     = '0;
    scl_pull_low = '0;
    sda_pull_low = '0;
    lfsr_q       = 32'h43b;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_cycles(1);
    reset_defaults();
    line_control();
    take_random(4, r);
    port = int'(r) % NUM_PORTS;
    interference_flagged(port);
    interference_ignored(port);
    strobes_and_decode();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
hdl/i3c_phy_pkg.sv
hdl/dff_2sync.sv
hdl/i3c_phy.sv
hdl/i3c_phy_regs.sv
hdl/i3c_err_collect.sv
hdl/i3c_phy_array.sv
bench/i3c_phy_array_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := i3c_phy_array_tb
DUT_TOP    := i3c_phy_array
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
